//--- hdl/spi_pkg.sv
package spi_pkg;

    // bits moved in each direction per frame
    localparam int FRAME_BITS = 40;

    // width of the bit-rate divider setting
    localparam int DIV_WIDTH = 3;

    // slave select lines and the width of their index
    localparam int CS_COUNT = 4;
    localparam int CS_SEL_WIDTH = 2;

    // serial clock edges in one frame, one fall and one rise per bit
    localparam int EDGE_COUNT = 2 * FRAME_BITS;

    // tick count where chip select is released after the last rise
    localparam int HOLD_COUNT = EDGE_COUNT + 1;

    // parking count, held until send_enable is seen low
    localparam int DONE_COUNT = EDGE_COUNT + 2;

    // frame controller tick counter, counts 0 up to DONE_COUNT
    localparam int BIT_COUNT_WIDTH = $clog2(DONE_COUNT + 1);

    typedef logic [FRAME_BITS-1:0] frame_t;

endpackage

//--- hdl/spi_shift_if.sv
`timescale 1ns/1ps

interface spi_shift_if;

    // copy the transmit word into the shifter
    logic load;

    // next bit onto mosi, on a falling sclk edge
    logic shift_out;

    // capture miso, on a rising sclk edge
    logic sample_in;

    // publish the received word
    logic frame_end;

    modport ctrl
    (
        output load,
        output shift_out,
        output sample_in,
        output frame_end
    );

    modport shifter
    (
        input load,
        input shift_out,
        input sample_in,
        input frame_end
    );

endinterface

//--- hdl/spi_tick_divider.sv
`timescale 1ns/1ps

module spi_tick_divider
(
    input  logic                            clk_in,
    input  logic                            reset,
    input  logic [spi_pkg::DIV_WIDTH-1:0]   clk_count_max,
    output logic                            tick
);

    logic [spi_pkg::DIV_WIDTH-1:0] count;

    // one tick per clk_count_max + 1 cycles
    assign tick = (count == '0);

    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            count <= clk_count_max;
        end
        else if (count == '0)
        begin
            // reload picks up a new setting at the period boundary
            count <= clk_count_max;
        end
        else
        begin
            count <= count - 1'b1;
        end
    end

endmodule

//--- hdl/spi_frame_ctrl.sv
`timescale 1ns/1ps

module spi_frame_ctrl
(
    input  logic            clk_in,
    input  logic            reset,
    input  logic            tick,
    input  logic            send_enable,
    output logic            sclk,
    output logic            cs_active,
    output logic            frame_done,
    spi_shift_if.ctrl       shift
);

    localparam logic [spi_pkg::BIT_COUNT_WIDTH-1:0] EDGE_LAST =
        spi_pkg::BIT_COUNT_WIDTH'(spi_pkg::EDGE_COUNT);
    localparam logic [spi_pkg::BIT_COUNT_WIDTH-1:0] HOLD_AT =
        spi_pkg::BIT_COUNT_WIDTH'(spi_pkg::HOLD_COUNT);
    localparam logic [spi_pkg::BIT_COUNT_WIDTH-1:0] DONE_AT =
        spi_pkg::BIT_COUNT_WIDTH'(spi_pkg::DONE_COUNT);

    // 0 idle, 1..EDGE_LAST clock edges, HOLD_AT cs release, DONE_AT parked
    logic [spi_pkg::BIT_COUNT_WIDTH-1:0] bit_count;

    logic step;
    logic idle;
    logic in_edges;
    logic fall_edge;
    logic frame_end_hit;

    // every action needs a tick with the host still asking for the frame
    assign step      = tick && send_enable;
    assign idle      = (bit_count == '0);
    assign in_edges  = (bit_count != '0) && (bit_count <= EDGE_LAST);
    // odd counts are falling edges since sclk idles high
    assign fall_edge = bit_count[0];

    assign frame_end_hit = step && (bit_count == HOLD_AT);

    assign shift.load      = step && idle;
    // the first fall carries no shift, the load already put bit one on mosi
    assign shift.shift_out = step && in_edges && fall_edge && (bit_count != 1);
    assign shift.sample_in = step && in_edges && !fall_edge;
    assign shift.frame_end = frame_end_hit;

    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            bit_count  <= '0;
            sclk       <= 1'b1;
            cs_active  <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= frame_end_hit;
            if (tick)
            begin
                if (!send_enable)
                begin
                    // re-arm, or abort a frame in flight
                    bit_count <= '0;
                    sclk      <= 1'b1;
                    cs_active <= 1'b0;
                end
                else if (bit_count != DONE_AT)
                begin
                    bit_count <= bit_count + 1'b1;
                    if (idle)
                    begin
                        cs_active <= 1'b1;
                    end
                    if (in_edges)
                    begin
                        sclk <= !sclk;
                    end
                    if (bit_count == HOLD_AT)
                    begin
                        cs_active <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/spi_shift_reg.sv
`timescale 1ns/1ps

module spi_shift_reg
(
    input  logic                clk_in,
    input  logic                reset,
    input  spi_pkg::frame_t     data_in,
    input  logic                miso,
    output logic                mosi,
    output spi_pkg::frame_t     data_out,
    spi_shift_if.shifter        shift
);

    spi_pkg::frame_t tx_word;
    spi_pkg::frame_t rx_word;

    // msb first, the top bit is always on the line
    assign mosi = tx_word[spi_pkg::FRAME_BITS-1];

    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            tx_word <= '0;
        end
        else if (shift.load)
        begin
            tx_word <= data_in;
        end
        else if (shift.shift_out)
        begin
            tx_word <= {tx_word[spi_pkg::FRAME_BITS-2:0], 1'b0};
        end
    end

    // miso enters at the bottom and walks up to the msb
    always_ff @(posedge clk_in)
    begin
        if (shift.sample_in)
        begin
            rx_word <= {rx_word[spi_pkg::FRAME_BITS-2:0], miso};
        end
    end

    // host view only moves at the end of a complete frame
    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            data_out <= '0;
        end
        else if (shift.frame_end)
        begin
            data_out <= rx_word;
        end
    end

endmodule

//--- hdl/spi_cs_decoder.sv
`timescale 1ns/1ps

module spi_cs_decoder
(
    input  logic                                clk_in,
    input  logic                                reset,
    input  logic                                cs_active,
    input  logic [spi_pkg::CS_SEL_WIDTH-1:0]    cs_select,
    output logic [spi_pkg::CS_COUNT-1:0]        cs_n
);

    logic [spi_pkg::CS_COUNT-1:0] cs_n_next;

    // one-cold decode, all lines high when no frame is active
    always_comb
    begin
        cs_n_next = '1;
        if (cs_active)
        begin
            cs_n_next[cs_select] = 1'b0;
        end
    end

    // registered so the select lines come straight from flops
    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            cs_n <= '1;
        end
        else
        begin
            cs_n <= cs_n_next;
        end
    end

endmodule

//--- hdl/spi_master.sv
`timescale 1ns/1ps

module spi_master
(
    input  logic                                clk_in,
    input  logic                                reset,
    input  spi_pkg::frame_t                     data_in,
    input  logic [spi_pkg::DIV_WIDTH-1:0]       clk_count_max,
    input  logic                                send_enable,
    input  logic [spi_pkg::CS_SEL_WIDTH-1:0]    cs_select,
    input  logic                                miso,
    output spi_pkg::frame_t                     data_out,
    output logic                                sclk,
    output logic                                mosi,
    output logic [spi_pkg::CS_COUNT-1:0]        cs_n,
    output logic                                frame_done
);

    logic tick;
    logic cs_active;

    spi_shift_if shift_bus ();

    // bit-rate enable, all flops stay on clk_in
    spi_tick_divider i_spi_tick_divider
    (
        .clk_in         (clk_in),
        .reset          (reset),
        .clk_count_max  (clk_count_max),
        .tick           (tick)
    );

    spi_frame_ctrl i_spi_frame_ctrl
    (
        .clk_in         (clk_in),
        .reset          (reset),
        .tick           (tick),
        .send_enable    (send_enable),
        .sclk           (sclk),
        .cs_active      (cs_active),
        .frame_done     (frame_done),
        .shift          (shift_bus.ctrl)
    );

    spi_shift_reg i_spi_shift_reg
    (
        .clk_in         (clk_in),
        .reset          (reset),
        .data_in        (data_in),
        .miso           (miso),
        .mosi           (mosi),
        .data_out       (data_out),
        .shift          (shift_bus.shifter)
    );

    // cs_n lags cs_active by one clk_in cycle
    spi_cs_decoder i_spi_cs_decoder
    (
        .clk_in         (clk_in),
        .reset          (reset),
        .cs_active      (cs_active),
        .cs_select      (cs_select),
        .cs_n           (cs_n)
    );

endmodule

//--- testbench/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;

    localparam int FRAMES = 30;
    // longest frame at the slowest divider setting, with some margin
    localparam int FRAME_TIMEOUT = (spi_pkg::DONE_COUNT + 8) * (1 << spi_pkg::DIV_WIDTH);

    logic                                   clk_in = 1'b0;
    logic                                   reset;
    spi_pkg::frame_t                        data_in;
    logic [spi_pkg::DIV_WIDTH-1:0]          clk_count_max;
    logic                                   send_enable;
    logic [spi_pkg::CS_SEL_WIDTH-1:0]       cs_select;
    logic                                   miso;
    spi_pkg::frame_t                        data_out;
    logic                                   sclk;
    logic                                   mosi;
    logic [spi_pkg::CS_COUNT-1:0]           cs_n;
    logic                                   frame_done;

    // reference model of the frame in flight
    spi_pkg::frame_t                        exp_data;
    spi_pkg::frame_t                        exp_resp;
    logic [spi_pkg::CS_SEL_WIDTH-1:0]       exp_sel;
    int                                     exp_div;

    integer         seed;
    logic [31:0]    rnd;
    logic [63:0]    wide;
    bit             got_done;
    int             host_errors;
    int             slave_errors;
    int             timeouts;

    // slave and bus monitor state
    logic               prev_sclk;
    logic               prev_cs_high;
    logic               prev_done;
    logic               cs_high;
    spi_pkg::frame_t    prev_data_out;
    spi_pkg::frame_t    mosi_word;
    int                 rises;
    int                 falls;
    int                 edges;
    int                 bit_idx;
    longint             now;
    longint             last_edge;

    spi_master i_spi_master
    (
        .clk_in         (clk_in),
        .reset          (reset),
        .data_in        (data_in),
        .clk_count_max  (clk_count_max),
        .send_enable    (send_enable),
        .cs_select      (cs_select),
        .miso           (miso),
        .data_out       (data_out),
        .sclk           (sclk),
        .mosi           (mosi),
        .cs_n           (cs_n),
        .frame_done     (frame_done)
    );

    always #10 clk_in = ~clk_in;

    task automatic wait_frame_done(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < FRAME_TIMEOUT)
        begin
            @(posedge clk_in);
            #2;
            cycles++;
            if (frame_done)
            begin
                ok = 1'b1;
            end
        end
        if (!ok)
        begin
            $display("timeout: no frame_done within %0d clock cycles", FRAME_TIMEOUT);
        end
    endtask

    // behavioral slave and bus checks, sampled after each clk_in edge
    initial
    begin
        miso = 1'b0;
        slave_errors = 0;
        prev_sclk = 1'b1;
        prev_cs_high = 1'b1;
        prev_done = 1'b0;
        prev_data_out = '0;
        mosi_word = '0;
        rises = 0;
        falls = 0;
        edges = 0;
        bit_idx = 0;
        last_edge = 0;
        forever
        begin
            @(posedge clk_in);
            #2;
            cs_high = &cs_n;
            now = $time;
            if (!reset)
            begin
                if (prev_cs_high && !cs_high)
                begin
                    // frame opens, the first response bit goes out right away
                    rises = 0;
                    falls = 0;
                    edges = 0;
                    mosi_word = '0;
                    bit_idx = spi_pkg::FRAME_BITS - 1;
                    miso = exp_resp[bit_idx];
                end
                if (!cs_high && cs_n != ~(spi_pkg::CS_COUNT'(1) << exp_sel))
                begin
                    $display("ERROR at %0d ns: cs_n %b for cs_select %0d", $time, cs_n, exp_sel);
                    slave_errors++;
                end
                if (cs_high && !sclk)
                begin
                    $display("ERROR at %0d ns: sclk low with all chip selects high", $time);
                    slave_errors++;
                end
                if (sclk != prev_sclk)
                begin
                    if (cs_high)
                    begin
                        $display("ERROR at %0d ns: sclk edge outside chip select", $time);
                        slave_errors++;
                    end
                    if (edges > 0 && now - last_edge != 20 * (longint'(exp_div) + 1))
                    begin
                        $display("ERROR at %0d ns: sclk edge spacing %0d ns, divider %0d",
                                 $time, now - last_edge, exp_div);
                        slave_errors++;
                    end
                    edges++;
                    last_edge = now;
                    if (!sclk)
                    begin
                        falls++;
                        // first fall keeps the bit shown at chip select
                        if (falls > 1 && bit_idx > 0)
                        begin
                            bit_idx--;
                            miso = exp_resp[bit_idx];
                        end
                    end
                    else
                    begin
                        rises++;
                        mosi_word = {mosi_word[spi_pkg::FRAME_BITS-2:0], mosi};
                    end
                end
                if (!prev_cs_high && cs_high)
                begin
                    if (rises != spi_pkg::FRAME_BITS)
                    begin
                        $display("ERROR at %0d ns: %0d sclk rises in frame", $time, rises);
                        slave_errors++;
                    end
                    if (mosi_word != exp_data)
                    begin
                        $display("ERROR at %0d ns: slave got %h, expected %h",
                                 $time, mosi_word, exp_data);
                        slave_errors++;
                    end
                end
                if (data_out != prev_data_out && !frame_done)
                begin
                    $display("ERROR at %0d ns: data_out moved without frame_done", $time);
                    slave_errors++;
                end
                if (frame_done && prev_done)
                begin
                    $display("ERROR at %0d ns: frame_done wider than one cycle", $time);
                    slave_errors++;
                end
            end
            prev_sclk = sclk;
            prev_cs_high = cs_high;
            prev_done = frame_done;
            prev_data_out = data_out;
        end
    end

    initial
    begin
        seed = 54965;
        host_errors = 0;
        timeouts = 0;
        reset = 1'b1;
        data_in = '0;
        clk_count_max = '0;
        send_enable = 1'b0;
        cs_select = '0;
        exp_data = '0;
        exp_resp = '0;
        exp_sel = '0;
        exp_div = 0;
        repeat (16) @(posedge clk_in);
        #2;
        reset = 1'b0;
        for (int frame = 0; frame < FRAMES && timeouts == 0; frame++)
        begin
            // new divider, slave, payload and response while the bus is idle
            rnd = $random(seed);
            clk_count_max = rnd[spi_pkg::DIV_WIDTH-1:0];
            exp_div = int'(rnd[spi_pkg::DIV_WIDTH-1:0]);
            cs_select = rnd[8 +: spi_pkg::CS_SEL_WIDTH];
            exp_sel = rnd[8 +: spi_pkg::CS_SEL_WIDTH];
            wide = {$random(seed), $random(seed)};
            data_in = wide[spi_pkg::FRAME_BITS-1:0];
            exp_data = wide[spi_pkg::FRAME_BITS-1:0];
            wide = {$random(seed), $random(seed)};
            exp_resp = wide[spi_pkg::FRAME_BITS-1:0];
            @(posedge clk_in);
            #2;
            send_enable = 1'b1;
            wait_frame_done(got_done);
            if (!got_done)
            begin
                timeouts++;
            end
            else
            begin
                if (data_out != exp_resp)
                begin
                    $display("ERROR at %0d ns: data_out %h, expected %h",
                             $time, data_out, exp_resp);
                    host_errors++;
                end
                // level still high, no second frame may start
                repeat (4 * (exp_div + 1))
                begin
                    @(posedge clk_in);
                    #2;
                    if (frame_done || !(&cs_n) || !sclk)
                    begin
                        $display("ERROR at %0d ns: bus active while send_enable held",
                                 $time);
                        host_errors++;
                    end
                end
                send_enable = 1'b0;
                // long enough for one tick to see the low level
                repeat (exp_div + 2)
                begin
                    @(posedge clk_in);
                    #2;
                end
            end
        end
        $display("errors: host %0d, slave %0d, timeouts %0d",
                 host_errors, slave_errors, timeouts);
        if (host_errors == 0 && slave_errors == 0 && timeouts == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/spi_pkg.sv
hdl/spi_shift_if.sv
hdl/spi_tick_divider.sv
hdl/spi_frame_ctrl.sv
hdl/spi_shift_reg.sv
hdl/spi_cs_decoder.sv
hdl/spi_master.sv
testbench/tb_spi_master.sv

//--- run.sh
#!/bin/sh
# compile and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f build.f --top-module tb_spi_master \
    --Mdir "$OBJ" -o tb_spi_master
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/tb_spi_master" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
